//--- design/issue_pkg.sv
package issue_pkg;

  //////////////////////////////
  // widths
  //////////////////////////////

  localparam int INST_WIDTH           = 32; // instruction word.
  localparam int ADDR_WIDTH           = 32; // program counter.
  localparam int INSTRUCTION_ID_WIDTH = 8;  // wraps modulo 256.
  localparam int REG_IDX_WIDTH        = 5;  // 32 registers.
  localparam int OPCODE_WIDTH         = 6;

  typedef logic [INST_WIDTH-1:0]           inst_t;
  typedef logic [ADDR_WIDTH-1:0]           addr_t;
  typedef logic [INSTRUCTION_ID_WIDTH-1:0] inst_id_t;
  typedef logic [REG_IDX_WIDTH-1:0]        reg_idx_t;
  typedef logic [OPCODE_WIDTH-1:0]         opcode_t;
  typedef logic [2:0]                      reg_mask_t;  // rs, rt, rd usage.
  typedef logic [2:0]                      pipe_mask_t; // pc, if/id, id/ex.
  typedef logic [1:0]                      mem_op_t;

  //////////////////////////////
  // instruction fields
  //////////////////////////////

  localparam int OPCODE_MSB = 31;
  localparam int OPCODE_LSB = 26;
  localparam int REG_RS_MSB = 25;
  localparam int REG_RS_LSB = 21;
  localparam int REG_RT_MSB = 20;
  localparam int REG_RT_LSB = 16;
  localparam int REG_RD_MSB = 15;
  localparam int REG_RD_LSB = 11;

  //////////////////////////////
  // opcodes
  //////////////////////////////

  localparam logic [1:0] OP_CLASS_REG    = 2'b00; // add, sub...
  localparam logic [1:0] OP_CLASS_IMM    = 2'b01; // addi, subi...
  localparam logic [1:0] OP_CLASS_MEM    = 2'b10; // lw, sw, la, sa.
  localparam logic [1:0] OP_CLASS_BRANCH = 2'b11; // jmp, jo, je...

  localparam opcode_t OP_CODE_NOP = 6'b000000;
  localparam opcode_t OP_CODE_JR  = 6'b001000; // jump register, reg class.
  localparam opcode_t OP_CODE_LW  = 6'b100011;
  localparam opcode_t OP_CODE_SW  = 6'b101011;
  localparam opcode_t OP_CODE_LA  = 6'b100000; // load absolute, no base reg.
  localparam opcode_t OP_CODE_SA  = 6'b101000; // store absolute.

  //////////////////////////////
  // masks
  //////////////////////////////

  localparam reg_mask_t REG_MASK_RS = 3'b001;
  localparam reg_mask_t REG_MASK_RT = 3'b010;
  localparam reg_mask_t REG_MASK_RD = 3'b100;

  localparam pipe_mask_t PIPE_REG_PC    = 3'b001;
  localparam pipe_mask_t PIPE_REG_IF_ID = 3'b010;
  localparam pipe_mask_t PIPE_REG_ID_EX = 3'b100;

  localparam mem_op_t MEM_OP_NONE  = 2'd0;
  localparam mem_op_t MEM_OP_READ  = 2'd1;
  localparam mem_op_t MEM_OP_WRITE = 2'd2;

  localparam inst_t NOP_INSTRUCTION = '0; // bubble.

endpackage

//--- design/operand_decoder.sv
`timescale 1ns/1ns

module operand_decoder import issue_pkg::*; (
  input  inst_t     instruction,
  output reg_idx_t  rs,
  output reg_idx_t  rt,
  output reg_idx_t  rd,
  output reg_mask_t src_mask,
  output reg_mask_t dst_mask,
  output mem_op_t   mem_op
);

  opcode_t opcode;

  assign opcode = instruction[OPCODE_MSB:OPCODE_LSB];
  assign rs     = instruction[REG_RS_MSB:REG_RS_LSB];
  assign rt     = instruction[REG_RT_MSB:REG_RT_LSB];
  assign rd     = instruction[REG_RD_MSB:REG_RD_LSB];

  // register usage by opcode class.
  always_comb begin
    src_mask = '0; // default covers nop and branches.
    dst_mask = '0;
    mem_op   = MEM_OP_NONE;
    if (opcode == OP_CODE_NOP) begin
      src_mask = '0; // bubble touches nothing.
    end else if (opcode == OP_CODE_JR) begin
      src_mask = REG_MASK_RS; // target from rs.
    end else begin
      case (opcode[OPCODE_WIDTH-1 -: 2])
        OP_CLASS_REG: begin
          src_mask = REG_MASK_RS | REG_MASK_RT;
          dst_mask = REG_MASK_RD;
        end
        OP_CLASS_IMM: begin
          src_mask = REG_MASK_RS;
          dst_mask = REG_MASK_RT; // immediate form writes rt.
        end
        OP_CLASS_MEM: begin
          case (opcode)
            OP_CODE_LW: begin
              src_mask = REG_MASK_RS; // base.
              dst_mask = REG_MASK_RT;
              mem_op   = MEM_OP_READ;
            end
            OP_CODE_SW: begin
              src_mask = REG_MASK_RS | REG_MASK_RT; // base and data.
              mem_op   = MEM_OP_WRITE;
            end
            OP_CODE_LA: begin
              dst_mask = REG_MASK_RT; // absolute address, no base.
              mem_op   = MEM_OP_READ;
            end
            OP_CODE_SA: begin
              src_mask = REG_MASK_RT; // data only.
              mem_op   = MEM_OP_WRITE;
            end
            default: mem_op = MEM_OP_NONE; // unused memory opcode.
          endcase
        end
        OP_CLASS_BRANCH: src_mask = '0; // flags only.
        default: src_mask = '0;
      endcase
    end
  end

endmodule

//--- design/hazard_detection_unit.sv
`timescale 1ns/1ns

module hazard_detection_unit import issue_pkg::*; (
  input  inst_t      load_instruction,
  input  inst_t      instruction0_in,
  input  inst_t      instruction1_in,
  input  addr_t      pc0_in,
  input  addr_t      pc1_in,
  input  inst_id_t   id0_in,
  input  inst_id_t   id1_in,
  output pipe_mask_t stall0,
  output pipe_mask_t flush0,
  output pipe_mask_t stall1,
  output pipe_mask_t flush1,
  output addr_t      split_pc0,
  output addr_t      split_pc1,
  output inst_id_t   split_id0,
  output inst_id_t   split_id1,
  output inst_t      split_instruction0,
  output inst_t      split_instruction1
);

  reg_idx_t  rs0, rt0, rd0;
  reg_idx_t  rs1, rt1, rd1;
  reg_mask_t src_mask0, dst_mask0;
  reg_mask_t src_mask1, dst_mask1;
  reg_idx_t  load_rt;
  mem_op_t   load_mem_op;

  logic load_stall;
  logic split_stall;
  logic first; // high when slot 1 holds the older instruction.
  logic issue0, issue1;

  // true when the reader's sources hit the writer's destination.
  function automatic logic depends(input reg_mask_t src, input reg_idx_t rs,
                                   input reg_idx_t rt, input reg_mask_t dst,
                                   input reg_idx_t w_rt, input reg_idx_t w_rd);
    reg_idx_t w_idx;
    w_idx = |(dst & REG_MASK_RD) ? w_rd : w_rt;
    return (|dst) && ((|(src & REG_MASK_RS) && rs == w_idx) ||
                      (|(src & REG_MASK_RT) && rt == w_idx));
  endfunction

  operand_decoder u_dec0 (
    .instruction(instruction0_in), .rs(rs0), .rt(rt0), .rd(rd0),
    .src_mask(src_mask0), .dst_mask(dst_mask0), .mem_op()
  );

  operand_decoder u_dec1 (
    .instruction(instruction1_in), .rs(rs1), .rt(rt1), .rd(rd1),
    .src_mask(src_mask1), .dst_mask(dst_mask1), .mem_op()
  );

  operand_decoder u_dec_load (
    .instruction(load_instruction), .rs(), .rt(load_rt), .rd(),
    .src_mask(), .dst_mask(), .mem_op(load_mem_op)
  );

  //////////////////////////////
  // hazard checks
  //////////////////////////////

  assign load_stall = (load_mem_op == MEM_OP_READ) &&
                      (rs0 == load_rt || rt0 == load_rt ||
                       rs1 == load_rt || rt1 == load_rt); // raw fields, conservative.

  assign first = (id0_in == inst_id_t'(id1_in + 1'b1)); // ids in program order.

  assign split_stall = !load_stall &&
    (first ? depends(src_mask0, rs0, rt0, dst_mask1, rt1, rd1)   // slot 0 younger.
           : depends(src_mask1, rs1, rt1, dst_mask0, rt0, rd0)); // slot 1 younger.

  // stall and flush masks per slot.
  always_comb begin
    stall0 = '0;
    flush0 = '0;
    stall1 = '0;
    flush1 = '0;
    if (load_stall) begin
      stall0 = PIPE_REG_PC | PIPE_REG_IF_ID; // hold bundle one cycle.
      flush0 = PIPE_REG_ID_EX;              // bubble behind the load.
      stall1 = PIPE_REG_PC | PIPE_REG_IF_ID;
      flush1 = PIPE_REG_ID_EX;
    end else if (split_stall && first) begin
      stall1 = PIPE_REG_PC;                 // older issues now.
      flush1 = PIPE_REG_IF_ID;              // and leaves if/id.
      stall0 = PIPE_REG_PC | PIPE_REG_IF_ID; // younger waits.
      flush0 = PIPE_REG_ID_EX;
    end else if (split_stall) begin
      stall0 = PIPE_REG_PC;
      flush0 = PIPE_REG_IF_ID;
      stall1 = PIPE_REG_PC | PIPE_REG_IF_ID;
      flush1 = PIPE_REG_ID_EX;
    end
  end

  //////////////////////////////
  // issued bundle
  //////////////////////////////

  assign issue0 = !load_stall && !(split_stall && first); // slot 0 zeroed if younger.
  assign issue1 = !load_stall && !(split_stall && !first);

  assign split_pc0          = issue0 ? pc0_in : '0;
  assign split_id0          = issue0 ? id0_in : '0;
  assign split_instruction0 = issue0 ? instruction0_in : NOP_INSTRUCTION;
  assign split_pc1          = issue1 ? pc1_in : '0;
  assign split_id1          = issue1 ? id1_in : '0;
  assign split_instruction1 = issue1 ? instruction1_in : NOP_INSTRUCTION;

endmodule

//--- design/pipe_slot_reg.sv
`timescale 1ns/1ns

module pipe_slot_reg import issue_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  logic     stall,
  input  logic     flush,
  input  addr_t    pc_in,
  input  inst_id_t id_in,
  input  inst_t    instruction_in,
  output addr_t    pc,
  output inst_id_t id,
  output inst_t    instruction
);

  // one slot of the pipeline.
  always_ff @(posedge clk or negedge rst_n) begin
    if (!rst_n) begin
      pc          <= '0;
      id          <= '0;
      instruction <= NOP_INSTRUCTION; // empty slot after reset.
    end else if (flush) begin
      pc          <= '0; // flush wins over stall.
      id          <= '0;
      instruction <= NOP_INSTRUCTION;
    end else if (!stall) begin
      pc          <= pc_in;
      id          <= id_in;
      instruction <= instruction_in;
    end
  end

endmodule

//--- design/issue_stage.sv
`timescale 1ns/1ns

module issue_stage import issue_pkg::*; (
  input  logic     clk,
  input  logic     rst_n,
  input  inst_t    instruction0_in,
  input  inst_t    instruction1_in,
  input  addr_t    pc0_in,
  input  addr_t    pc1_in,
  input  inst_id_t id0_in,
  input  inst_id_t id1_in,
  output logic     pc_stall,
  output inst_t    instruction0_out,
  output inst_t    instruction1_out,
  output addr_t    pc0_out,
  output addr_t    pc1_out,
  output inst_id_t id0_out,
  output inst_id_t id1_out
);

  // if/id slot contents.
  addr_t    if_id_pc0, if_id_pc1;
  inst_id_t if_id_id0, if_id_id1;
  inst_t    if_id_instruction0, if_id_instruction1;

  // hazard unit results.
  pipe_mask_t stall0, flush0, stall1, flush1;
  addr_t      split_pc0, split_pc1;
  inst_id_t   split_id0, split_id1;
  inst_t      split_instruction0, split_instruction1;

  assign pc_stall = |(stall0 & PIPE_REG_PC); // fetch holds its bundle.

  //////////////////////////////
  // if/id
  //////////////////////////////

  pipe_slot_reg if_id0 (
    .clk(clk), .rst_n(rst_n),
    .stall(|(stall0 & PIPE_REG_IF_ID)), .flush(|(flush0 & PIPE_REG_IF_ID)),
    .pc_in(pc0_in), .id_in(id0_in), .instruction_in(instruction0_in),
    .pc(if_id_pc0), .id(if_id_id0), .instruction(if_id_instruction0)
  );

  pipe_slot_reg if_id1 (
    .clk(clk), .rst_n(rst_n),
    .stall(|(stall1 & PIPE_REG_IF_ID)), .flush(|(flush1 & PIPE_REG_IF_ID)),
    .pc_in(pc1_in), .id_in(id1_in), .instruction_in(instruction1_in),
    .pc(if_id_pc1), .id(if_id_id1), .instruction(if_id_instruction1)
  );

  //////////////////////////////
  // hazards
  //////////////////////////////

  hazard_detection_unit u_hazard (
    .load_instruction(instruction1_out), // memory ops live in slot 1 only.
    .instruction0_in(if_id_instruction0), .instruction1_in(if_id_instruction1),
    .pc0_in(if_id_pc0), .pc1_in(if_id_pc1),
    .id0_in(if_id_id0), .id1_in(if_id_id1),
    .stall0(stall0), .flush0(flush0), .stall1(stall1), .flush1(flush1),
    .split_pc0(split_pc0), .split_pc1(split_pc1),
    .split_id0(split_id0), .split_id1(split_id1),
    .split_instruction0(split_instruction0), .split_instruction1(split_instruction1)
  );

  //////////////////////////////
  // id/ex
  //////////////////////////////

  pipe_slot_reg id_ex0 (
    .clk(clk), .rst_n(rst_n),
    .stall(|(stall0 & PIPE_REG_ID_EX)), .flush(|(flush0 & PIPE_REG_ID_EX)),
    .pc_in(split_pc0), .id_in(split_id0), .instruction_in(split_instruction0),
    .pc(pc0_out), .id(id0_out), .instruction(instruction0_out)
  );

  pipe_slot_reg id_ex1 (
    .clk(clk), .rst_n(rst_n),
    .stall(|(stall1 & PIPE_REG_ID_EX)), .flush(|(flush1 & PIPE_REG_ID_EX)),
    .pc_in(split_pc1), .id_in(split_id1), .instruction_in(split_instruction1),
    .pc(pc1_out), .id(id1_out), .instruction(instruction1_out)
  );

endmodule

//--- test/issue_stage_tb.sv
`timescale 1ns/1ns

module issue_stage_tb import issue_pkg::*; ();

  localparam int MAX_ITEMS      = 64;
  localparam int TIMEOUT_CYCLES = 40; // per test.

  typedef logic [INST_WIDTH+ADDR_WIDTH+INSTRUCTION_ID_WIDTH-1:0] slot_t; // inst, pc, id.

  logic     clk = 1'b0;
  logic     rst_n;
  inst_t    instruction0_in, instruction1_in;
  addr_t    pc0_in, pc1_in;
  inst_id_t id0_in, id1_in;
  logic     pc_stall;
  inst_t    instruction0_out, instruction1_out;
  addr_t    pc0_out, pc1_out;
  inst_id_t id0_out, id1_out;

  slot_t bun0[MAX_ITEMS], bun1[MAX_ITEMS]; // bundles to present.
  slot_t exp0[MAX_ITEMS], exp1[MAX_ITEMS]; // expected issue cycles, all zero is a bubble.
  int    nb, ne;
  int    errors, test_errors, tests_run, tests_failed;

  issue_stage DUT (.*);

  always #2 clk = ~clk; // 4 ns period.

  //////////////////////////////
  // compare tasks
  //////////////////////////////

  task automatic check_inst(input string name, input inst_t got, input inst_t want);
    if (got !== want) begin
      $display("CHECK FAILED %s: got %h, expected %h", name, got, want);
      test_errors++;
    end
  endtask

  task automatic check_pc(input string name, input addr_t got, input addr_t want);
    if (got !== want) begin
      $display("CHECK FAILED %s: got %h, expected %h", name, got, want);
      test_errors++;
    end
  endtask

  task automatic check_id(input string name, input inst_id_t got, input inst_id_t want);
    if (got !== want) begin
      $display("CHECK FAILED %s: got %h, expected %h", name, got, want);
      test_errors++;
    end
  endtask

  task automatic check_stall(input string name, input logic got, input logic want);
    if (got !== want) begin
      $display("CHECK FAILED %s: got %h, expected %h", name, got, want);
      test_errors++;
    end
  endtask

  // one issue slot against its expected record.
  task automatic check_slot(input int slot, input inst_t gi, input addr_t gp,
                            input inst_id_t gd, input slot_t want);
    inst_t    wi;
    addr_t    wp;
    inst_id_t wd;
    {wi, wp, wd} = want;
    check_inst($sformatf("instruction%0d_out", slot), gi, wi);
    check_pc($sformatf("pc%0d_out", slot), gp, wp);
    check_id($sformatf("id%0d_out", slot), gd, wd);
  endtask

  // reg class op, registers drawn from lo..hi.
  function automatic inst_t make_alu(input int lo, input int hi);
    return {opcode_t'($urandom_range(7, 1)), reg_idx_t'($urandom_range(hi, lo)),
            reg_idx_t'($urandom_range(hi, lo)), reg_idx_t'($urandom_range(hi, lo)),
            11'($urandom)};
  endfunction

  task automatic finish_test(input logic [8*24-1:0] name);
    tests_run++;
    errors += test_errors;
    if (test_errors == 0) begin
      $display("%0s: passed", name);
    end else begin
      tests_failed++;
      $display("%0s: failed with %0d errors", name, test_errors);
    end
  endtask

  // presents the bundles and follows the issue outputs.
  task automatic run_test(input logic [8*24-1:0] name, input int want_stalls);
    int bi, ei, cycles, stalls, take_cycle;
    bi = 0;
    ei = 0;
    cycles = 0;
    stalls = 0;
    take_cycle = 0;
    test_errors = 0;
    while (ei < ne && cycles < TIMEOUT_CYCLES) begin
      @(negedge clk);
      {instruction0_in, pc0_in, id0_in} = (bi < nb) ? bun0[bi] : '0; // zeros once done.
      {instruction1_in, pc1_in, id1_in} = (bi < nb) ? bun1[bi] : '0;
      @(posedge clk);
      cycles++;
      if (pc_stall) stalls++;
      if (want_stalls == 0) check_stall("pc_stall", pc_stall, 1'b0);
      if (!pc_stall && bi < nb) begin // bundle taken at this edge.
        if (bi == 0) take_cycle = cycles; // records follow 2 cycles later, one per cycle.
        bi++;
      end
      if (instruction0_out != NOP_INSTRUCTION || instruction1_out != NOP_INSTRUCTION ||
          (exp0[ei] == '0 && exp1[ei] == '0)) begin
        if (cycles != take_cycle + 2 + ei) begin
          $display("%0s: issue cycle %0d came %0d cycles after the first bundle, not %0d",
                   name, ei, cycles - take_cycle, 2 + ei);
          test_errors++;
        end
        check_slot(0, instruction0_out, pc0_out, id0_out, exp0[ei]);
        check_slot(1, instruction1_out, pc1_out, id1_out, exp1[ei]);
        ei++;
      end
    end
    if (ei < ne) begin
      $display("%0s: timed out after %0d cycles waiting for issue cycle %0d", name, cycles, ei);
      test_errors++;
    end
    if (stalls != want_stalls) begin
      $display("%0s: pc_stall was high for %0d cycles instead of %0d", name, stalls, want_stalls);
      test_errors++;
    end
    repeat (3) begin // drain, nothing more may issue.
      @(posedge clk);
      check_inst("instruction0_out", instruction0_out, NOP_INSTRUCTION);
      check_inst("instruction1_out", instruction1_out, NOP_INSTRUCTION);
    end
  endtask

  //////////////////////////////
  // main sequence
  //////////////////////////////

  initial begin
    int               fd, seed, count, stall_want, n, k, slot_a, slot_b;
    logic [8*120-1:0] line;
    logic [8*16-1:0]  key;
    logic [8*24-1:0]  name;
    inst_t            ia, ib;
    addr_t            pa, pb;
    inst_id_t         da, db;
    seed = $urandom(32'h2fee);
    errors = 0;
    tests_run = 0;
    tests_failed = 0;
    test_errors = 0;
    rst_n = 1'b0;
    {instruction0_in, instruction1_in, pc0_in, pc1_in, id0_in, id1_in} = '0;
    repeat (4) @(posedge clk);
    check_stall("pc_stall", pc_stall, 1'b0); // empty pipe after reset.
    check_slot(0, instruction0_out, pc0_out, id0_out, '0);
    check_slot(1, instruction1_out, pc1_out, id1_out, '0);
    finish_test("reset");
    @(negedge clk);
    rst_n = 1'b1;
    fd = $fopen("test/issue_input.txt", "r");
    if (fd == 0) begin
      $display("could not open test/issue_input.txt");
      errors++;
    end
    while (fd != 0 && !$feof(fd)) begin
      line = '0;
      key = '0;
      if ($fgets(line, fd) == 0) continue;
      n = $sscanf(line, "%s", key); // comment and blank lines match no key.
      if (key == "test") begin
        n = $sscanf(line, "%s %s %d", key, name, stall_want);
        nb = 0;
        ne = 0;
      end else if (key == "bundle") begin
        n = $sscanf(line, "%s %h %h %h %h %h %h", key, ia, ib, pa, pb, da, db);
        bun0[nb] = {ia, pa, da};
        bun1[nb] = {ib, pb, db};
        nb++;
      end else if (key == "issue") begin
        n = $sscanf(line, "%s %d %h %h %h %d %h %h %h", key, slot_a, ia, pa, da,
                    slot_b, ib, pb, db);
        exp0[ne] = '0; // unnamed slot must hold a nop.
        exp1[ne] = '0;
        if (slot_a == 0) exp0[ne] = {ia, pa, da};
        else exp1[ne] = {ia, pa, da};
        if (n == 9 && slot_b == 0) exp0[ne] = {ib, pb, db};
        if (n == 9 && slot_b == 1) exp1[ne] = {ib, pb, db};
        ne++;
      end else if (key == "bubble") begin
        exp0[ne] = '0;
        exp1[ne] = '0;
        ne++;
      end else if (key == "random") begin
        n = $sscanf(line, "%s %d %h %h", key, count, pa, da);
        for (k = 0; k < count; k++) begin
          bun0[nb] = {make_alu(1, 15), addr_t'(pa + 8 * k), inst_id_t'(da + 2 * k)};
          bun1[nb] = {make_alu(16, 31), addr_t'(pa + 8 * k + 4), inst_id_t'(da + 2 * k + 1)};
          exp0[ne] = bun0[nb]; // disjoint registers, issues as presented.
          exp1[ne] = bun1[nb];
          nb++;
          ne++;
        end
      end else if (key == "end") begin
        run_test(name, stall_want);
        finish_test(name);
      end
    end
    if (fd != 0) $fclose(fd);
    $display("tests run %0d, passed %0d, failed %0d, check errors %0d",
             tests_run, tests_run - tests_failed, tests_failed, errors);
    if (errors == 0) begin
      $display("Finished with no errors");
    end else begin
      $display("Finished with errors");
    end
    $finish;
  end

endmodule

//--- dual_issue_hazard.f
design/issue_pkg.sv
design/operand_decoder.sv
design/hazard_detection_unit.sv
design/pipe_slot_reg.sv
design/issue_stage.sv
test/issue_stage_tb.sv

//--- Bender.yml
package:
  name: dual_issue_hazard

sources:
  - design/issue_pkg.sv
  - design/operand_decoder.sv
  - design/hazard_detection_unit.sv
  - design/pipe_slot_reg.sv
  - design/issue_stage.sv
  - target: test
    files:
      - test/issue_stage_tb.sv

//--- test/issue_input.txt
# test <name> <pc_stall cycles>; bundle <inst0> <inst1> <pc0> <pc1> <id0> <id1>
# issue <slot> <inst> <pc> <id> [<slot> <inst> <pc> <id>] per cycle; bubble; random <n> <pc> <id>
test independent 0
bundle 04221800 04853000 00000200 00000204 20 21
issue 0 04221800 00000200 20 1 04853000 00000204 21
end
test load_use 1
bundle 04221800 8c850000 00000100 00000104 0a 0b
bundle 04a73000 052a4000 00000108 0000010c 0c 0d
issue 0 04221800 00000100 0a 1 8c850000 00000104 0b
bubble
issue 0 04a73000 00000108 0c 1 052a4000 0000010c 0d
end
test split_slot0_older 1
bundle 04221800 04643000 00000300 00000304 30 31
issue 0 04221800 00000300 30
issue 1 04643000 00000304 31
end
test split_slot1_older 1
bundle 04643000 04221800 00000404 00000400 41 40
issue 1 04221800 00000400 40
issue 0 04643000 00000404 41
end
test random_alu 0
random 20 00000500 50
end
